//--- rtl/lcd_pkg.sv
package lcd_pkg;

	// one 10-bit command word seen two ways
	typedef union packed {
		struct packed {
			logic       rs;
			logic       rw;
			logic [7:0] data;
		} raw;
		struct packed {
			logic       rs;
			logic       rw;
			logic       set_addr; // bit 7 of a set-DDRAM-address instruction
			logic [6:0] addr;
		} ddram;
	} lcd_word_u;

	localparam logic [7:0] INSTR_CLEAR = 8'h01;
	localparam logic [7:0] INSTR_HOME  = 8'h02;
	localparam logic [6:0] LINE2_BASE  = 7'h40; // first cell of line 2

	localparam int LINE_LEN = 16; // visible cells per line

	// panel timing in microseconds
	localparam int T_POWERUP_US = 500;
	localparam int T_CMD_US     = 50;   // normal command window
	localparam int T_LONG_US    = 2000; // clear and home
	localparam int T_E_ON_US    = 1;
	localparam int T_E_OFF_US   = 14;
	localparam int T_INIT_E_US  = 10;   // enable width of each init instruction

	// low time after function set, display control, clear, entry mode
	localparam int T_INIT_GAP_US [4] = '{50, 50, 200, 100};

endpackage

//--- rtl/lcd_cmd_if.sv
`timescale 1ns/1ps

interface lcd_cmd_if;
	logic               valid; // one command this cycle
	lcd_pkg::lcd_word_u word;
	logic               credit; // receiver freed one slot

	modport sender (
		output valid,
		output word,
		input  credit
	);

	modport receiver (
		input  valid,
		input  word,
		output credit
	);
endinterface

//--- rtl/lcd_cmd_queue.sv
`timescale 1ns/1ps

module lcd_cmd_queue #(
	parameter int QUEUE_DEPTH = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               host_valid,
	input  lcd_pkg::lcd_word_u host_word,
	output logic               host_credit,
	lcd_cmd_if.sender          out
);

	localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CW = $clog2(QUEUE_DEPTH + 1);
	localparam logic [1:0] SEQ_SLOTS = 2'd2; // holding buffer in the sequencer

	lcd_pkg::lcd_word_u mem [QUEUE_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic [1:0]    out_cnt; // credits toward the sequencer
	logic          full;
	logic          pop;

	function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
		return (p == AW'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == CW'(QUEUE_DEPTH));
	assign pop  = (count != '0) && (out_cnt != 2'd0); // oldest entry leaves

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			out_cnt     <= SEQ_SLOTS;
			out.valid   <= 1'b0;
			host_credit <= 1'b0;
		end else begin
			if (host_valid)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			count       <= count + CW'(host_valid) - CW'(pop);
			out_cnt     <= out_cnt - {1'b0, pop} + {1'b0, out.credit};
			out.valid   <= pop;
			host_credit <= pop; // slot is free as the entry goes out
		end
	end

	always_ff @(posedge clk) begin
		if (host_valid)
			mem[wr_ptr] <= host_word;
		if (pop)
			out.word <= mem[rd_ptr];
	end

	// the host only writes with a credit in hand, so a full buffer sees no write
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		full |-> !host_valid)
		else $error("host wrote into a full command queue");

endmodule

//--- rtl/lcd_line_sequencer.sv
`timescale 1ns/1ps

module lcd_line_sequencer (
	input  logic        clk,
	input  logic        rst,
	lcd_cmd_if.receiver in,
	lcd_cmd_if.sender   out
);

	localparam logic [1:0] DRV_CREDITS = 2'd1; // driver takes one command at a time
	localparam logic [6:0] LINE1_END = 7'(lcd_pkg::LINE_LEN);
	localparam logic [6:0] LINE2_END = lcd_pkg::LINE2_BASE + 7'(lcd_pkg::LINE_LEN);

	lcd_pkg::lcd_word_u hold [2];
	logic               wr_sel;
	logic               rd_sel;
	logic [1:0]         used;
	logic [6:0]         cursor; // DDRAM address the panel will write next
	logic [1:0]         out_cnt;
	lcd_pkg::lcd_word_u head;
	lcd_pkg::lcd_word_u wrap_word;
	logic               is_char;
	logic               is_set_addr;
	logic               is_clear_home;
	logic               wrap;
	logic               send;
	logic               pop;

	assign head = hold[rd_sel];

	assign is_char = head.raw.rs && !head.raw.rw;
	assign is_set_addr = !head.ddram.rs && !head.ddram.rw && head.ddram.set_addr;
	assign is_clear_home = !head.raw.rs && !head.raw.rw &&
		(head.raw.data == lcd_pkg::INSTR_CLEAR || head.raw.data == lcd_pkg::INSTR_HOME);

	// char about to land past the visible end of a line
	assign wrap = is_char && (cursor == LINE1_END || cursor == LINE2_END);

	always_comb begin
		wrap_word.ddram.rs       = 1'b0;
		wrap_word.ddram.rw       = 1'b0;
		wrap_word.ddram.set_addr = 1'b1;
		wrap_word.ddram.addr     = (cursor == LINE1_END) ? lcd_pkg::LINE2_BASE : 7'd0;
	end

	assign send = (used != 2'd0) && (out_cnt != 2'd0);
	assign pop  = send && !wrap; // inserted address goes first, head stays

	assign out.valid = send;
	assign out.word  = wrap ? wrap_word : head;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_sel    <= 1'b0;
			rd_sel    <= 1'b0;
			used      <= 2'd0;
			cursor    <= 7'd0;
			out_cnt   <= DRV_CREDITS;
			in.credit <= 1'b0;
		end else begin
			if (in.valid)
				wr_sel <= !wr_sel;
			if (pop)
				rd_sel <= !rd_sel;
			used      <= used + {1'b0, in.valid} - {1'b0, pop};
			out_cnt   <= out_cnt - {1'b0, send} + {1'b0, out.credit};
			in.credit <= pop;

			if (send) begin
				if (wrap)
					cursor <= wrap_word.ddram.addr;
				else if (is_set_addr)
					cursor <= head.ddram.addr;
				else if (is_clear_home)
					cursor <= 7'd0;
				else if (is_char)
					cursor <= cursor + 7'd1; // increment mode, no shift
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid)
			hold[wr_sel] <= in.word;
	end

	// a credit only comes back for a command the driver still holds
	a_credit_balance: assert property (@(posedge clk) disable iff (rst)
		out.credit |-> out_cnt != DRV_CREDITS)
		else $error("bus driver returned a credit it was never given");

endmodule

//--- rtl/lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver #(
	parameter int CLK_PER_US = 15
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [6:0]  lcd_mode, // lines, font, display, cursor, blink, inc, shift
	lcd_cmd_if.receiver cmd,
	output logic        e,
	output logic        rs,
	output logic        rw,
	output logic [7:0]  lcd_data,
	output logic        busy
);

	localparam int CNT_MAX = ((lcd_pkg::T_LONG_US > lcd_pkg::T_POWERUP_US) ?
		lcd_pkg::T_LONG_US : lcd_pkg::T_POWERUP_US) * CLK_PER_US;
	localparam int CW = $clog2(CNT_MAX + 1);

	localparam logic [CW-1:0] PWR_LAST  = CW'(lcd_pkg::T_POWERUP_US * CLK_PER_US - 1);
	localparam logic [CW-1:0] CMD_LAST  = CW'(lcd_pkg::T_CMD_US * CLK_PER_US - 1);
	localparam logic [CW-1:0] LONG_LAST = CW'(lcd_pkg::T_LONG_US * CLK_PER_US - 1);
	localparam logic [CW-1:0] E_ON      = CW'(lcd_pkg::T_E_ON_US * CLK_PER_US);
	localparam logic [CW-1:0] E_OFF     = CW'(lcd_pkg::T_E_OFF_US * CLK_PER_US);
	localparam logic [CW-1:0] INIT_E    = CW'(lcd_pkg::T_INIT_E_US * CLK_PER_US);

	localparam logic [1:0] ST_PWRUP = 2'd0;
	localparam logic [1:0] ST_INIT  = 2'd1;
	localparam logic [1:0] ST_IDLE  = 2'd2;
	localparam logic [1:0] ST_CMD   = 2'd3;

	logic [1:0]         state;
	logic [CW-1:0]      cnt; // cycles into the current step
	logic [1:0]         init_idx;
	logic               pending; // command that came in before idle
	lcd_pkg::lcd_word_u cmd_word;
	logic [7:0]         init_code;
	logic [CW-1:0]      init_last;
	logic [CW-1:0]      cmd_last;
	logic               long_cmd;
	logic               init_e;
	logic               cmd_e;

	always_comb begin
		case (init_idx)
			2'd0: init_code = {4'b0011, lcd_mode[6], lcd_mode[5], 2'b00}; // function set
			2'd1: init_code = {5'b00001, lcd_mode[4], lcd_mode[3], lcd_mode[2]};
			2'd2: init_code = lcd_pkg::INSTR_CLEAR;
			default: init_code = {6'b000001, lcd_mode[1], lcd_mode[0]}; // entry mode
		endcase
	end

	assign init_last = CW'((lcd_pkg::T_INIT_E_US + lcd_pkg::T_INIT_GAP_US[init_idx]) *
		CLK_PER_US - 1);

	// clear and home need the long window
	assign long_cmd = !cmd_word.raw.rs && !cmd_word.raw.rw &&
		(cmd_word.raw.data == lcd_pkg::INSTR_CLEAR || cmd_word.raw.data == lcd_pkg::INSTR_HOME);
	assign cmd_last = long_cmd ? LONG_LAST : CMD_LAST;

	assign init_e = (state == ST_INIT) && (cnt < INIT_E);
	assign cmd_e  = (state == ST_CMD) && (cnt >= E_ON) && (cnt < E_OFF);

	assign e        = init_e || cmd_e;
	assign rs       = (state == ST_CMD) && cmd_word.raw.rs;
	assign rw       = (state == ST_CMD) && cmd_word.raw.rw; // passed through only
	assign lcd_data = (state == ST_CMD) ? cmd_word.raw.data : (init_e ? init_code : 8'h00);
	assign busy     = (state != ST_IDLE);

	assign cmd.credit = (state == ST_CMD) && (cnt == cmd_last); // window ends

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ST_PWRUP;
			cnt      <= '0;
			init_idx <= 2'd0;
			pending  <= 1'b0;
		end else begin
			if (cmd.valid)
				pending <= 1'b1;
			case (state)
				ST_PWRUP: begin
					if (cnt == PWR_LAST) begin
						cnt   <= '0;
						state <= ST_INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_INIT: begin
					if (cnt == init_last) begin
						cnt      <= '0;
						init_idx <= init_idx + 2'd1;
						if (init_idx == 2'd3)
							state <= ST_IDLE; // entry mode was the last one
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_IDLE: begin
					cnt <= '0;
					if (cmd.valid || pending) begin
						state   <= ST_CMD;
						pending <= 1'b0;
					end
				end
				default: begin
					if (cnt == cmd_last) begin
						cnt   <= '0;
						state <= ST_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.valid)
			cmd_word <= cmd.word;
	end

	a_e_quiet: assert property (@(posedge clk) disable iff (rst)
		(state == ST_PWRUP || state == ST_IDLE) |-> !e)
		else $error("enable high outside init and command window");

	// panel latches on the falling edge, bus must not move under a high enable
	a_bus_stable: assert property (@(posedge clk) disable iff (rst)
		e ##1 e |-> $stable({rs, rw, lcd_data}))
		else $error("bus changed while enable was high");

	// window and its word hold until the credit goes back
	a_cmd_to_idle: assert property (@(posedge clk) disable iff (rst)
		state == ST_CMD && !cmd.credit |=> state == ST_CMD && $stable(cmd_word))
		else $error("command window cut short or its word replaced");

endmodule

//--- rtl/lcd_display_top.sv
`timescale 1ns/1ps

module lcd_display_top #(
	parameter int CLK_PER_US  = 15,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst,
	input  logic [6:0] lcd_mode,
	input  logic       host_valid,
	input  logic [9:0] host_word, // {rs, rw, data}
	output logic       host_credit,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	lcd_pkg::lcd_word_u host_entry;

	lcd_cmd_if q2s ();
	lcd_cmd_if s2d ();

	assign host_entry = host_word;

	lcd_cmd_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) lcd_cmd_queue_i (
		.clk        (clk),
		.rst        (rst),
		.host_valid (host_valid),
		.host_word  (host_entry),
		.host_credit(host_credit),
		.out        (q2s.sender)
	);

	lcd_line_sequencer lcd_line_sequencer_i (
		.clk(clk),
		.rst(rst),
		.in (q2s.receiver),
		.out(s2d.sender)
	);

	lcd_bus_driver #(
		.CLK_PER_US(CLK_PER_US)
	) lcd_bus_driver_i (
		.clk     (clk),
		.rst     (rst),
		.lcd_mode(lcd_mode),
		.cmd     (s2d.receiver),
		.e       (e),
		.rs      (rs),
		.rw      (rw),
		.lcd_data(lcd_data),
		.busy    (busy)
	);

endmodule

//--- tests/lcd_display_tb.sv
`timescale 1ns/1ps

module lcd_display_tb;

	localparam int QUEUE_DEPTH = 4;
	localparam int N_ENTRIES   = 80;
	localparam int TIMEOUT     = 50000; // cycles, covers several clear windows
	localparam logic [6:0] MODE = 7'b1010010; // two lines, display on, increment, no shift
	localparam logic [6:0] LINE2_ADDR = 7'h40;
	localparam logic [6:0] LINE_CELLS = 7'd16;

	logic       clk = 1'b0;
	logic       rst;
	logic [6:0] lcd_mode;
	logic       host_valid;
	logic [9:0] host_word;
	logic       host_credit;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;
	logic       busy;

	logic [9:0]  expected [$]; // bus words in the order the panel must see them
	logic [9:0]  captured = '0;
	logic        e_last = 1'b0;
	logic [6:0]  model_cursor = 7'd0;
	int unsigned lcg_state = 19;
	int          sent = 0;
	int          returned = 0;
	int          checked = 0;

	lcd_display_top #(
		.CLK_PER_US (2),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) lcd_display_top_i (
		.clk        (clk),
		.rst        (rst),
		.lcd_mode   (lcd_mode),
		.host_valid (host_valid),
		.host_word  (host_word),
		.host_credit(host_credit),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

	always #5 clk = !clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [9:0] got, input logic [9:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	function automatic int unsigned next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// first entries are all characters so that line 1 overflows at least once
	function automatic logic [9:0] pick_word(input int idx);
		int unsigned r;
		logic [6:0]  addr;
		r = next_rand();
		if (idx < 20 || r % 32 < 26)
			return {2'b10, 8'h20 + 8'(r / 32 % 95)}; // printable character
		if (r % 32 == 31)
			return 10'h001; // clear
		addr = 7'(r / 32 % 16);
		if (((r / 512) & 1) == 1)
			addr = addr + LINE2_ADDR;
		return {3'b001, addr};
	endfunction

	// panel cursor rule with wrap insertion, increment mode only
	task automatic push_host_word(input logic [9:0] w);
		if (w[9] && !w[8]) begin
			if (model_cursor == LINE_CELLS) begin
				expected.push_back({3'b001, LINE2_ADDR});
				model_cursor = LINE2_ADDR;
			end else if (model_cursor == LINE2_ADDR + LINE_CELLS) begin
				expected.push_back(10'h080);
				model_cursor = 7'd0;
			end
			model_cursor = model_cursor + 7'd1;
		end else if (w[9:7] == 3'b001) begin
			model_cursor = w[6:0];
		end else if (w == 10'h001 || w == 10'h002) begin
			model_cursor = 7'd0;
		end
		expected.push_back(w);
	endtask

	// bus monitor, sampled mid-cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (host_credit)
				returned = returned + 1;
			if (sent - returned < 0 || sent - returned > QUEUE_DEPTH)
				abort_run("host credit count left the range 0 to QUEUE_DEPTH");
			if (checked < 4)
				check_value("busy", 10'(busy), 10'd1); // still initializing
			if (e && e_last)
				check_value("bus during enable", {rs, rw, lcd_data}, captured);
			if (e)
				captured = {rs, rw, lcd_data};
			if (!e && e_last) begin
				if (expected.size() == 0) begin
					abort_run("enable pulse seen while no bus word was expected");
				end else begin
					check_value("bus word", captured, expected.pop_front());
					checked++;
				end
			end
			e_last = e;
		end
	end

	initial begin
		int         wait_cnt;
		int         gap;
		logic [9:0] w;
		rst        <= 1'b1;
		lcd_mode   <= MODE;
		host_valid <= 1'b0;
		host_word  <= '0;
		expected.push_back(10'h038); // function set, 8 bit, two lines, 5x8
		expected.push_back(10'h00C); // display on, cursor and blink off
		expected.push_back(10'h001);
		expected.push_back(10'h006); // increment, no shift
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < N_ENTRIES; i++) begin
			w = pick_word(i);
			gap = int'(next_rand() % 6);
			repeat (gap) @(posedge clk);
			wait_cnt = 0;
			while (sent - returned >= QUEUE_DEPTH) begin
				if (wait_cnt == TIMEOUT)
					abort_run("host stalled too long waiting for a queue credit");
				wait_cnt++;
				@(posedge clk);
			end
			host_valid <= 1'b1;
			host_word  <= w;
			sent++;
			push_host_word(w);
			@(posedge clk);
			host_valid <= 1'b0;
		end

		wait_cnt = 0;
		while (expected.size() != 0 || sent != returned || busy) begin
			if (wait_cnt == TIMEOUT)
				abort_run("bus did not drain all entries and go idle in time");
			wait_cnt++;
			@(negedge clk);
		end
		repeat (200) @(negedge clk); // any stray enable pulse shows up here

		if (busy) begin
			abort_run("bus driver opened a command window after the queue drained");
		end else begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

//--- filelist.f
rtl/lcd_pkg.sv
rtl/lcd_cmd_if.sv
rtl/lcd_cmd_queue.sv
rtl/lcd_line_sequencer.sv
rtl/lcd_bus_driver.sv
rtl/lcd_display_top.sv
tests/lcd_display_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lcd_display_tb -f filelist.f

status=0
output=$(./obj_dir/Vlcd_display_tb 2>&1) || status=$?
echo "$output"
echo "simulation exit status: $status"
echo "$output" | grep -q "TESTS PASSED"
